//--- Makefile
VERILATOR ?= verilator
TOP       ?= decode_pipe_tb
FLIST     ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for failures"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/decode_pipe_properties.sv
/*
 * Concurrent assertions on the decode pipeline top,
 * attached to every decode_pipe instance by bind
 */
`timescale 1ns/1ns

module decode_pipe_properties (
    input logic                 clk_i,
    input logic                 rst_i,
    input logic                 inst_valid_i,
    input logic                 out_valid_o,
    input decode_pkg::dec_out_t dec_o
);

    // Fixed three-cycle latency in both directions
    a_latency_fwd: assert property (@(posedge clk_i) disable iff (rst_i)
        inst_valid_i |-> ##3 out_valid_o) else $error("valid strobe lost in pipeline");
    a_latency_bwd: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_o |-> $past(inst_valid_i, 3)) else $error("output without matching issue");

    a_ri_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        (out_valid_o && dec_o.exc.ri) |-> (!dec_o.wreg && !dec_o.isbranch))
        else $error("reserved instruction with active controls");
    a_flag_branch: assert property (@(posedge clk_i) disable iff (rst_i)
        (out_valid_o && dec_o.br_flag) |-> dec_o.isbranch)
        else $error("branch taken on a non-branch");

    a_reset_quiet: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
        else $error("output strobe right after reset");

endmodule

bind decode_pipe decode_pipe_properties u_decode_pipe_properties (.*);

//--- sim/decode_pipe_tb.sv
/*
 * Table-driven testbench for the decode pipeline: clock, reset,
 * register preload from an LCG, issue loop, checker and watchdog
 */
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_pipe_tb;

    import decode_pkg::*;

    typedef struct {
        logic [31:0] inst;
        logic [31:0] pc;
        alu_op_e     aluop;
        logic        wreg;
        logic [4:0]  wraddr;
        br_cond_e    kind;
        logic [31:0] tgt;
        logic [2:0]  exc;   // ri, sys, bp
        int          s1;    // Register number, -1 immediate, -2 not checked
        int          s2;
        logic [31:0] imm;
        logic [4:0]  prew;  // Register written just before issue
    } row_t;

    typedef struct {
        int       due;
        dec_out_t d;
        bit       chk1;
        bit       chk2;
    } exp_t;

    logic        clk_i;
    logic        rst_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic        wb_we_i;
    logic [4:0]  wb_addr_i;
    logic [31:0] wb_data_i;
    logic        out_valid_o;
    dec_out_t    dec_o;

    row_t        rows[$];
    exp_t        exp_q[$];
    logic [31:0] reg_copy [0:31];
    logic [31:0] lcg_state = 32'hfcb7;
    int          ncyc = 0;
    int          checks = 0;
    int          errors = 0;

    decode_pipe u_decode_pipe (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] r_word(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                           logic [4:0] sa, logic [5:0] fn);
        return {6'b0, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_row(logic [31:0] inst, logic [31:0] pc, alu_op_e aluop, logic wreg,
                           logic [4:0] wraddr, br_cond_e kind, logic [31:0] tgt,
                           logic [2:0] exc, int s1, int s2, logic [31:0] imm,
                           logic [4:0] prew);
        row_t r;
        r = '{inst, pc, aluop, wreg, wraddr, kind, tgt, exc, s1, s2, imm, prew};
        rows.push_back(r);
    endtask

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic build_table();
        add_row(r_word(1, 2, 3, 0, `SP_ADDU), 32'h40, ALU_ADDU, 1, 3, BR_NONE, 0, 0, 1, 2, 0, 0);
        add_row(r_word(5, 6, 4, 0, `SP_SUB), 32'h44, ALU_SUB, 1, 4, BR_NONE, 0, 0, 5, 6, 0, 0);
        add_row(r_word(7, 8, 9, 0, `SP_NOR), 32'h48, ALU_NOR, 1, 9, BR_NONE, 0, 0, 7, 8, 0, 0);
        add_row(r_word(7, 8, 10, 0, `SP_SLT), 32'h4c, ALU_SLT, 1, 10, BR_NONE, 0, 0, 7, 8, 0, 0);
        add_row(r_word(0, 2, 11, 5, `SP_SLL), 32'h50, ALU_SLL, 1, 11, BR_NONE, 0, 0, -1, 2, 5, 0);
        add_row(r_word(3, 4, 12, 0, `SP_SRAV), 32'h54, ALU_SRA, 1, 12, BR_NONE, 0, 0, 3, 4, 0, 0);
        add_row(r_word(1, 2, 11, 5, `SP_SLL), 32'h58, ALU_NOP, 0, 0, BR_NONE, 0, 4, -2, -2, 0, 0);
        add_row(i_word(`OP_ADDI, 1, 13, 16'hfff0), 32'h60, ALU_ADD, 1, 13, BR_NONE, 0, 0,
                1, -1, 32'hfffffff0, 0);
        add_row(i_word(`OP_SLTI, 7, 14, 16'h8000), 32'h64, ALU_SLT, 1, 14, BR_NONE, 0, 0,
                7, -1, 32'hffff8000, 0);
        add_row(i_word(`OP_ORI, 2, 15, 16'h8001), 32'h68, ALU_OR, 1, 15, BR_NONE, 0, 0,
                2, -1, 32'h00008001, 0);
        add_row(i_word(`OP_ANDI, 3, 16, 16'hffff), 32'h6c, ALU_AND, 1, 16, BR_NONE, 0, 0,
                3, -1, 32'h0000ffff, 0);
        add_row(i_word(`OP_LUI, 0, 17, 16'h1234), 32'h70, ALU_OR, 1, 17, BR_NONE, 0, 0,
                0, -1, 32'h12340000, 0);
        add_row(i_word(`OP_LW, 4, 18, 16'hfffc), 32'h74, ALU_LW, 1, 18, BR_NONE, 0, 0,
                4, -1, 32'hfffffffc, 0);
        add_row(i_word(`OP_SW, 5, 6, 16'h0010), 32'h78, ALU_SW, 0, 0, BR_NONE, 0, 0, 5, 6, 0, 0);
        // Conditional branches with r7 negative and r8 positive
        add_row(i_word(`OP_BEQ, 1, 1, 16'hfffc), 32'h100, ALU_NOP, 0, 0, BR_EQ, 32'hf4, 0,
                1, 1, 0, 0);
        add_row(i_word(`OP_BNE, 1, 1, 16'hfff0), 32'h200, ALU_NOP, 0, 0, BR_NE, 32'h1c4, 0,
                1, 1, 0, 0);
        add_row(i_word(`OP_BEQ, 0, 1, 16'h0008), 32'h300, ALU_NOP, 0, 0, BR_EQ, 32'h324, 0,
                0, 1, 0, 0);
        add_row(i_word(`OP_BNE, 0, 1, 16'hfff8), 32'h380, ALU_NOP, 0, 0, BR_NE, 32'h364, 0,
                0, 1, 0, 0);
        add_row(i_word(`OP_BLEZ, 7, 0, 16'hffff), 32'h400, ALU_NOP, 0, 0, BR_LEZ, 32'h400, 0,
                7, -2, 0, 0);
        add_row(i_word(`OP_BLEZ, 8, 0, 16'hfff8), 32'h500, ALU_NOP, 0, 0, BR_LEZ, 32'h4e4, 0,
                8, -2, 0, 0);
        add_row(i_word(`OP_BGTZ, 8, 0, 16'h0004), 32'h600, ALU_NOP, 0, 0, BR_GTZ, 32'h614, 0,
                8, -2, 0, 0);
        add_row(i_word(`OP_BGTZ, 0, 0, 16'hfffe), 32'h700, ALU_NOP, 0, 0, BR_GTZ, 32'h6fc, 0,
                0, -2, 0, 0);
        add_row(i_word(`OP_REGIMM, 7, `RI_BLTZ, 16'hfffc), 32'h800, ALU_NOP, 0, 0, BR_LTZ,
                32'h7f4, 0, 7, -2, 0, 0);
        add_row(i_word(`OP_REGIMM, 7, `RI_BGEZ, 16'hfffc), 32'h900, ALU_NOP, 0, 0, BR_GEZ,
                32'h8f4, 0, 7, -2, 0, 0);
        add_row(i_word(`OP_REGIMM, 8, `RI_BLTZAL, 16'h0010), 32'ha00, ALU_BAL, 1, 31, BR_LTZ,
                32'ha44, 0, 8, -2, 0, 0);
        add_row(i_word(`OP_REGIMM, 8, `RI_BGEZAL, 16'hff00), 32'hb00, ALU_BAL, 1, 31, BR_GEZ,
                32'h704, 0, 8, -2, 0, 0);
        // Jumps
        add_row({`OP_J, 26'h0000040}, 32'h1000_0000, ALU_NOP, 0, 0, BR_ALWAYS_IMM,
                32'h1000_0100, 0, -2, -2, 0, 0);
        add_row({`OP_JAL, 26'h3ffffff}, 32'h2000_0010, ALU_BAL, 1, 31, BR_ALWAYS_IMM,
                32'h2fff_fffc, 0, -2, -2, 0, 0);
        add_row(r_word(3, 0, 0, 0, `SP_JR), 32'hc00, ALU_NOP, 0, 0, BR_ALWAYS_REG, 0, 0,
                3, -2, 0, 0);
        add_row(r_word(4, 0, 19, 0, `SP_JALR), 32'hd00, ALU_BAL, 1, 19, BR_ALWAYS_REG, 0, 0,
                4, -2, 0, 0);
        // Exceptions
        add_row(r_word(0, 0, 0, 0, `SP_SYSCALL), 32'he00, ALU_NOP, 0, 0, BR_NONE, 0, 2,
                -2, -2, 0, 0);
        add_row({6'b0, 20'habcde, `SP_BREAK}, 32'he04, ALU_NOP, 0, 0, BR_NONE, 0, 1,
                -2, -2, 0, 0);
        add_row(32'hfc00_1234, 32'he08, ALU_NOP, 0, 0, BR_NONE, 0, 4, -2, -2, 0, 0);
        // Fresh write to r9 read by the next issue
        add_row(r_word(9, 1, 20, 0, `SP_ADDU), 32'hf00, ALU_ADDU, 1, 20, BR_NONE, 0, 0,
                9, 1, 0, 9);
    endtask

    task automatic write_reg(logic [4:0] addr, logic [31:0] data);
        @(posedge clk_i);
        inst_valid_i <= 1'b0;
        wb_we_i      <= 1'b1;
        wb_addr_i    <= addr;
        wb_data_i    <= data;
        reg_copy[addr] = data;
    endtask

    task automatic issue_row(row_t r);
        exp_t        e;
        logic [31:0] o1;
        logic [31:0] o2;
        logic        lez;
        o1  = (r.s1 >= 0) ? reg_copy[r.s1] : r.imm;
        o2  = (r.s2 >= 0) ? reg_copy[r.s2] : r.imm;
        lez = o1[31] || (o1 == 32'd0);
        e.d          = '0;
        e.d.pc       = r.pc;
        e.d.pcp4     = r.pc + 32'd4;
        e.d.aluop    = r.aluop;
        e.d.opr1     = o1;
        e.d.opr2     = o2;
        e.d.offset   = {{16{r.inst[15]}}, r.inst[15:0]};
        e.d.wreg     = r.wreg;
        e.d.wraddr   = r.wraddr;
        e.d.isbranch = (r.kind != BR_NONE);
        e.d.br_addr  = (r.kind == BR_ALWAYS_REG) ? o1 : r.tgt;
        e.d.exc      = r.exc;
        case (r.kind)
            BR_ALWAYS_IMM, BR_ALWAYS_REG: e.d.br_flag = 1'b1;
            BR_EQ:   e.d.br_flag = (o1 == o2);
            BR_NE:   e.d.br_flag = (o1 != o2);
            BR_LEZ:  e.d.br_flag = lez;
            BR_GTZ:  e.d.br_flag = !lez;
            BR_LTZ:  e.d.br_flag = o1[31];
            BR_GEZ:  e.d.br_flag = !o1[31];
            default: e.d.br_flag = 1'b0;
        endcase
        e.chk1 = (r.s1 != -2);
        e.chk2 = (r.s2 != -2);
        @(posedge clk_i);
        inst_valid_i <= 1'b1;
        inst_i       <= r.inst;
        pc_i         <= r.pc;
        wb_we_i      <= 1'b0;
        e.due = ncyc + 4;   // Output shows three edges after issue
        exp_q.push_back(e);
    endtask

    // Compare at the falling edge away from the drive edge
    always @(negedge clk_i) begin
        exp_t e;
        ncyc++;
        if (exp_q.size() > 0 && exp_q[0].due < ncyc) begin
            errors++;
            $display("Missing output at %0t for pc %h", $time, exp_q[0].d.pc);
            void'(exp_q.pop_front());
        end
        if (out_valid_o) begin
            if (exp_q.size() == 0 || exp_q[0].due != ncyc) begin
                errors++;
                $display("Unexpected output at %0t for pc %h", $time, dec_o.pc);
            end else begin
                e = exp_q.pop_front();
                check_val("pc", dec_o.pc, e.d.pc);
                check_val("pcp4", dec_o.pcp4, e.d.pcp4);
                check_val("aluop", dec_o.aluop, e.d.aluop);
                check_val("offset", dec_o.offset, e.d.offset);
                check_val("wreg", dec_o.wreg, e.d.wreg);
                if (e.d.wreg) check_val("wraddr", dec_o.wraddr, e.d.wraddr);
                if (e.chk1) check_val("opr1", dec_o.opr1, e.d.opr1);
                if (e.chk2) check_val("opr2", dec_o.opr2, e.d.opr2);
                check_val("isbranch", dec_o.isbranch, e.d.isbranch);
                check_val("br_flag", dec_o.br_flag, e.d.br_flag);
                check_val("br_addr", dec_o.br_addr, e.d.br_addr);
                check_val("exc", dec_o.exc, e.d.exc);
            end
        end
    end

    initial begin
        logic [31:0] v;
        int          gap;
        rst_i        = 1'b1;
        inst_valid_i = 1'b1;   // Strobe during reset must not come out
        inst_i       = '0;
        pc_i         = '0;
        wb_we_i      = 1'b0;
        wb_addr_i    = '0;
        wb_data_i    = '0;
        for (int i = 0; i < 32; i++) reg_copy[i] = '0;
        build_table();
        fork
            begin   // Watchdog allows about 4 cycles per row per pass
                repeat (rows.size() * 2 * 4 + 20 + 40) @(posedge clk_i);
                $display("Timeout, pipeline did not drain in time");
                $display("Errors found");
                $finish;
            end
        join_none
        repeat (2) @(posedge clk_i);
        inst_valid_i <= 1'b0;
        @(posedge clk_i);
        rst_i <= 1'b0;
        for (int r = 1; r <= 8; r++) begin
            v = lcg_next();
            if (r == 7) v[31] = 1'b1;   // Negative for LEZ/LTZ
            if (r == 8) v[31] = 1'b0;
            write_reg(r[4:0], v);
        end
        // Pass 0 with random gaps, pass 1 back to back
        for (int pass = 0; pass < 2; pass++) begin
            foreach (rows[i]) begin
                if (rows[i].prew != 0) write_reg(rows[i].prew, lcg_next());
                v   = lcg_next();
                gap = (pass == 0) ? int'(v % 3) : 0;
                repeat (gap) begin
                    @(posedge clk_i);
                    inst_valid_i <= 1'b0;
                    wb_we_i      <= 1'b0;
                end
                issue_row(rows[i]);
            end
        end
        @(posedge clk_i);
        inst_valid_i <= 1'b0;
        wait (exp_q.size() == 0);
        repeat (2) @(posedge clk_i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- source/control_decode_stage.sv
/*
 * Second decode stage: opcode, function and REGIMM decode
 * with reserved-field checks, immediate and target forming
 */
`timescale 1ns/1ns
`include "decode_defines.svh"

module control_decode_stage (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              valid_i,
    input  decode_pkg::cap_t  cap_i,
    output logic              valid_o,
    output decode_pkg::ctrl_t ctrl_o
);

    import decode_pkg::*;

    r_fmt_t               r;
    logic [15:0]          imm;
    logic [`DEC_XLEN-1:0] sign_ext;
    logic                 inst_ok;
    ctrl_t                nxt;

    assign r        = cap_i.inst.r_fmt;
    assign imm      = cap_i.inst.i_fmt.imm16;
    assign sign_ext = {{16{imm[15]}}, imm};

    always_comb begin
        nxt           = '0;
        nxt.pc        = cap_i.pc;
        nxt.pcp4      = cap_i.pcp4;
        nxt.aluop     = ALU_NOP;
        nxt.rs        = r.rs;
        nxt.rt        = r.rt;
        nxt.offset    = sign_ext;
        nxt.wraddr    = r.rd;
        nxt.br_cond   = BR_NONE;
        nxt.br_target = cap_i.pcp4 + {sign_ext[29:0], 2'b00};
        inst_ok       = 1'b0;

        case (r.opcode)
            `OP_SPECIAL: begin
                nxt.r1read = 1'b1;
                nxt.r2read = 1'b1;
                nxt.wreg   = 1'b1;
                inst_ok    = (r.sa == '0);
                case (r.funct)
                    `SP_SLL, `SP_SLLV: nxt.aluop = ALU_SLL;
                    `SP_SRL, `SP_SRLV: nxt.aluop = ALU_SRL;
                    `SP_SRA, `SP_SRAV: nxt.aluop = ALU_SRA;
                    `SP_ADD:  nxt.aluop = ALU_ADD;
                    `SP_ADDU: nxt.aluop = ALU_ADDU;
                    `SP_SUB:  nxt.aluop = ALU_SUB;
                    `SP_SUBU: nxt.aluop = ALU_SUBU;
                    `SP_AND:  nxt.aluop = ALU_AND;
                    `SP_OR:   nxt.aluop = ALU_OR;
                    `SP_XOR:  nxt.aluop = ALU_XOR;
                    `SP_NOR:  nxt.aluop = ALU_NOR;
                    `SP_SLT:  nxt.aluop = ALU_SLT;
                    `SP_SLTU: nxt.aluop = ALU_SLTU;
                    `SP_JR, `SP_JALR: begin
                        nxt.aluop   = (r.funct == `SP_JALR) ? ALU_BAL : ALU_NOP;
                        nxt.r2read  = 1'b0;
                        nxt.wreg    = (r.funct == `SP_JALR);  // Link into rd
                        nxt.br_cond = BR_ALWAYS_REG;
                        inst_ok     = ({r.rt, r.sa} == '0) &&
                                      ((r.funct == `SP_JALR) || (r.rd == '0));
                    end
                    `SP_SYSCALL, `SP_BREAK: begin
                        nxt.r1read  = 1'b0;
                        nxt.r2read  = 1'b0;
                        nxt.wreg    = 1'b0;
                        nxt.exc.sys = (r.funct == `SP_SYSCALL);
                        nxt.exc.bp  = (r.funct == `SP_BREAK);
                        inst_ok     = 1'b1;  // Code field is free
                    end
                    default: inst_ok = 1'b0;
                endcase
                // Constant shifts take sa instead of rs
                if (r.funct inside {`SP_SLL, `SP_SRL, `SP_SRA}) begin
                    nxt.r1read  = 1'b0;
                    nxt.ext_imm = {27'b0, r.sa};
                    inst_ok     = (r.rs == '0);
                end
            end

            // rt[0] picks GEZ over LTZ, rt[4] marks the linking forms
            `OP_REGIMM: begin
                nxt.r1read  = 1'b1;
                nxt.aluop   = r.rt[4] ? ALU_BAL : ALU_NOP;
                nxt.wreg    = r.rt[4];
                nxt.wraddr  = `DEC_GPR_RA;
                nxt.br_cond = r.rt[0] ? BR_GEZ : BR_LTZ;
                inst_ok     = r.rt inside {`RI_BLTZ, `RI_BGEZ, `RI_BLTZAL, `RI_BGEZAL};
            end

            `OP_J, `OP_JAL: begin
                nxt.aluop     = (r.opcode == `OP_JAL) ? ALU_BAL : ALU_NOP;
                nxt.wreg      = (r.opcode == `OP_JAL);
                nxt.wraddr    = `DEC_GPR_RA;
                nxt.br_cond   = BR_ALWAYS_IMM;
                nxt.br_target = {cap_i.pcp4[31:28], cap_i.inst.j_fmt.target26, 2'b00};
                inst_ok       = 1'b1;
            end

            `OP_BEQ, `OP_BNE: begin
                nxt.r1read  = 1'b1;
                nxt.r2read  = 1'b1;
                nxt.br_cond = (r.opcode == `OP_BEQ) ? BR_EQ : BR_NE;
                inst_ok     = 1'b1;
            end

            `OP_BLEZ, `OP_BGTZ: begin
                nxt.r1read  = 1'b1;
                nxt.br_cond = (r.opcode == `OP_BLEZ) ? BR_LEZ : BR_GTZ;
                inst_ok     = (r.rt == '0);
            end

            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI,
            `OP_ORI, `OP_XORI, `OP_LUI, `OP_LW: begin
                nxt.r1read  = 1'b1;  // LUI reads r0
                nxt.wreg    = 1'b1;
                nxt.wraddr  = r.rt;
                nxt.ext_imm = sign_ext;
                inst_ok     = 1'b1;
                case (r.opcode)
                    `OP_ADDI:  nxt.aluop = ALU_ADD;
                    `OP_ADDIU: nxt.aluop = ALU_ADDU;
                    `OP_SLTI:  nxt.aluop = ALU_SLT;
                    `OP_SLTIU: nxt.aluop = ALU_SLTU;
                    `OP_ANDI:  nxt.aluop = ALU_AND;
                    `OP_XORI:  nxt.aluop = ALU_XOR;
                    `OP_LW:    nxt.aluop = ALU_LW;
                    default:   nxt.aluop = ALU_OR;  // ORI and LUI
                endcase
                if (r.opcode inside {`OP_ANDI, `OP_ORI, `OP_XORI})
                    nxt.ext_imm = {16'b0, imm};
                if (r.opcode == `OP_LUI) begin
                    nxt.ext_imm = {imm, 16'b0};
                    inst_ok     = (r.rs == '0);
                end
            end

            `OP_SW: begin
                nxt.aluop  = ALU_SW;
                nxt.r1read = 1'b1;
                nxt.r2read = 1'b1;
                inst_ok    = 1'b1;
            end

            default: inst_ok = 1'b0;
        endcase

        // Reserved instruction leaves no side effects
        if (!inst_ok) begin
            nxt.aluop   = ALU_NOP;
            nxt.r1read  = 1'b0;
            nxt.r2read  = 1'b0;
            nxt.wreg    = 1'b0;
            nxt.br_cond = BR_NONE;
        end
        nxt.exc.ri = !inst_ok;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        ctrl_o <= nxt;
    end

endmodule

//--- source/decode_defines.svh
/*
 * Decode pipeline widths and register numbers
 * MIPS32 opcode, SPECIAL function and REGIMM rt codes
 */
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

`define DEC_XLEN        32
`define DEC_REG_AW      5
`define DEC_GPR_RA      5'd31       // Link register

// Primary opcodes
`define OP_SPECIAL      6'b000000
`define OP_REGIMM       6'b000001
`define OP_J            6'b000010
`define OP_JAL          6'b000011
`define OP_BEQ          6'b000100
`define OP_BNE          6'b000101
`define OP_BLEZ         6'b000110
`define OP_BGTZ         6'b000111
`define OP_ADDI         6'b001000
`define OP_ADDIU        6'b001001
`define OP_SLTI         6'b001010
`define OP_SLTIU        6'b001011
`define OP_ANDI         6'b001100
`define OP_ORI          6'b001101
`define OP_XORI         6'b001110
`define OP_LUI          6'b001111
`define OP_LW           6'b100011
`define OP_SW           6'b101011

// SPECIAL function field
`define SP_SLL          6'b000000
`define SP_SRL          6'b000010
`define SP_SRA          6'b000011
`define SP_SLLV         6'b000100
`define SP_SRLV         6'b000110
`define SP_SRAV         6'b000111
`define SP_JR           6'b001000
`define SP_JALR         6'b001001
`define SP_SYSCALL      6'b001100
`define SP_BREAK        6'b001101
`define SP_ADD          6'b100000
`define SP_ADDU         6'b100001
`define SP_SUB          6'b100010
`define SP_SUBU         6'b100011
`define SP_AND          6'b100100
`define SP_OR           6'b100101
`define SP_XOR          6'b100110
`define SP_NOR          6'b100111
`define SP_SLT          6'b101010
`define SP_SLTU         6'b101011

// REGIMM rt field
`define RI_BLTZ         5'b00000
`define RI_BGEZ         5'b00001
`define RI_BLTZAL       5'b10000
`define RI_BGEZAL       5'b10001

`endif

//--- source/decode_pipe.sv
/*
 * Three-stage decode pipeline top: capture, control decode,
 * operand/branch resolution and the general register file
 */
`timescale 1ns/1ns
`include "decode_defines.svh"

module decode_pipe (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   inst_valid_i,
    input  logic [`DEC_XLEN-1:0]   inst_i,
    input  logic [`DEC_XLEN-1:0]   pc_i,
    input  logic                   wb_we_i,
    input  logic [`DEC_REG_AW-1:0] wb_addr_i,
    input  logic [`DEC_XLEN-1:0]   wb_data_i,
    output logic                   out_valid_o,
    output decode_pkg::dec_out_t   dec_o
);

    import decode_pkg::*;

    logic                   c_valid;
    cap_t                   cap;
    logic                   d_valid;
    ctrl_t                  ctrl;
    logic [`DEC_REG_AW-1:0] rs_addr;
    logic [`DEC_REG_AW-1:0] rt_addr;
    logic [`DEC_XLEN-1:0]   rs_data;
    logic [`DEC_XLEN-1:0]   rt_data;

    inst_capture_stage u_inst_capture_stage (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (inst_valid_i),
        .inst_i  (inst_i),
        .pc_i    (pc_i),
        .valid_o (c_valid),
        .cap_o   (cap)
    );

    control_decode_stage u_control_decode_stage (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (c_valid),
        .cap_i   (cap),
        .valid_o (d_valid),
        .ctrl_o  (ctrl)
    );

    operand_branch_stage u_operand_branch_stage (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .valid_i   (d_valid),
        .ctrl_i    (ctrl),
        .rs_addr_o (rs_addr),
        .rt_addr_o (rt_addr),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .valid_o   (out_valid_o),
        .dec_o     (dec_o)
    );

    // Write port comes straight from the pins
    gpr_file u_gpr_file (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .we_i     (wb_we_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (rs_addr),
        .raddr2_i (rt_addr),
        .rdata1_o (rs_data),
        .rdata2_o (rt_data)
    );

endmodule

//--- source/decode_pkg.sv
/*
 * Decode pipeline types: instruction word union, ALU and
 * branch condition enums, exception flags, stage payloads
 */
`include "decode_defines.svh"

package decode_pkg;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`DEC_REG_AW-1:0] rs;
        logic [`DEC_REG_AW-1:0] rt;
        logic [`DEC_REG_AW-1:0] rd;
        logic [4:0]             sa;
        logic [5:0]             funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`DEC_REG_AW-1:0] rs;
        logic [`DEC_REG_AW-1:0] rt;
        logic [15:0]            imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } j_fmt_t;

    // One instruction word, three field layouts
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_SLL, ALU_SRL, ALU_SRA, ALU_ADD, ALU_ADDU,
        ALU_SUB, ALU_SUBU, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_BAL, ALU_LW, ALU_SW
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_ALWAYS_IMM,  // J, JAL
        BR_ALWAYS_REG,  // JR, JALR
        BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
    } br_cond_e;

    typedef struct packed {
        logic ri;
        logic sys;
        logic bp;
    } exc_t;

    typedef struct packed {
        inst_u                inst;
        logic [`DEC_XLEN-1:0] pc;
        logic [`DEC_XLEN-1:0] pcp4;
    } cap_t;

    typedef struct packed {
        logic [`DEC_XLEN-1:0]   pc;
        logic [`DEC_XLEN-1:0]   pcp4;
        alu_op_e                aluop;
        logic                   r1read;
        logic                   r2read;
        logic [`DEC_REG_AW-1:0] rs;
        logic [`DEC_REG_AW-1:0] rt;
        logic [`DEC_XLEN-1:0]   ext_imm;
        logic [`DEC_XLEN-1:0]   offset;
        logic                   wreg;
        logic [`DEC_REG_AW-1:0] wraddr;
        br_cond_e               br_cond;
        logic [`DEC_XLEN-1:0]   br_target;  // Jump or PC-relative target
        exc_t                   exc;
    } ctrl_t;

    typedef struct packed {
        logic [`DEC_XLEN-1:0]   pc;
        logic [`DEC_XLEN-1:0]   pcp4;
        alu_op_e                aluop;
        logic [`DEC_XLEN-1:0]   opr1;
        logic [`DEC_XLEN-1:0]   opr2;
        logic [`DEC_XLEN-1:0]   offset;
        logic                   wreg;
        logic [`DEC_REG_AW-1:0] wraddr;
        logic                   isbranch;
        logic                   br_flag;
        logic [`DEC_XLEN-1:0]   br_addr;
        exc_t                   exc;
    } dec_out_t;

endpackage

//--- source/gpr_file.sv
/*
 * General register file, two combinational reads and
 * one synchronous write, r0 hardwired to zero
 */
`timescale 1ns/1ns
`include "decode_defines.svh"

module gpr_file (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   we_i,
    input  logic [`DEC_REG_AW-1:0] waddr_i,
    input  logic [`DEC_XLEN-1:0]   wdata_i,
    input  logic [`DEC_REG_AW-1:0] raddr1_i,
    input  logic [`DEC_REG_AW-1:0] raddr2_i,
    output logic [`DEC_XLEN-1:0]   rdata1_o,
    output logic [`DEC_XLEN-1:0]   rdata2_o
);

    logic [`DEC_XLEN-1:0] regs [1:31];  // No storage for r0

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- source/inst_capture_stage.sv
/*
 * First decode stage: registers instruction word and pc,
 * computes pc+4 once for the later stages
 */
`timescale 1ns/1ns
`include "decode_defines.svh"

module inst_capture_stage (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 valid_i,
    input  logic [`DEC_XLEN-1:0] inst_i,
    input  logic [`DEC_XLEN-1:0] pc_i,
    output logic                 valid_o,
    output decode_pkg::cap_t     cap_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        cap_o.inst <= inst_i;
        cap_o.pc   <= pc_i;
        cap_o.pcp4 <= pc_i + `DEC_XLEN'd4;
    end

endmodule

//--- source/operand_branch_stage.sv
/*
 * Third decode stage: operand select from register file or
 * immediate, branch condition and branch address resolution
 */
`timescale 1ns/1ns
`include "decode_defines.svh"

module operand_branch_stage (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   valid_i,
    input  decode_pkg::ctrl_t      ctrl_i,
    output logic [`DEC_REG_AW-1:0] rs_addr_o,
    output logic [`DEC_REG_AW-1:0] rt_addr_o,
    input  logic [`DEC_XLEN-1:0]   rs_data_i,
    input  logic [`DEC_XLEN-1:0]   rt_data_i,
    output logic                   valid_o,
    output decode_pkg::dec_out_t   dec_o
);

    import decode_pkg::*;

    logic [`DEC_XLEN-1:0] opr1;
    logic [`DEC_XLEN-1:0] opr2;
    logic                 opr1_lez;
    dec_out_t             nxt;

    assign rs_addr_o = ctrl_i.rs;
    assign rt_addr_o = ctrl_i.rt;
    assign opr1      = ctrl_i.r1read ? rs_data_i : ctrl_i.ext_imm;
    assign opr2      = ctrl_i.r2read ? rt_data_i : ctrl_i.ext_imm;
    assign opr1_lez  = opr1[31] || (opr1 == '0);

    always_comb begin
        nxt.pc       = ctrl_i.pc;
        nxt.pcp4     = ctrl_i.pcp4;
        nxt.aluop    = ctrl_i.aluop;
        nxt.opr1     = opr1;
        nxt.opr2     = opr2;
        nxt.offset   = ctrl_i.offset;
        nxt.wreg     = ctrl_i.wreg;
        nxt.wraddr   = ctrl_i.wraddr;
        nxt.exc      = ctrl_i.exc;
        nxt.isbranch = (ctrl_i.br_cond != BR_NONE);
        nxt.br_addr  = ctrl_i.br_target;
        case (ctrl_i.br_cond)
            BR_ALWAYS_IMM: nxt.br_flag = 1'b1;
            BR_ALWAYS_REG: begin
                nxt.br_flag = 1'b1;
                nxt.br_addr = opr1;  // JR, JALR
            end
            BR_EQ:   nxt.br_flag = (opr1 == opr2);
            BR_NE:   nxt.br_flag = (opr1 != opr2);
            BR_LEZ:  nxt.br_flag = opr1_lez;
            BR_GTZ:  nxt.br_flag = !opr1_lez;
            BR_LTZ:  nxt.br_flag = opr1[31];
            BR_GEZ:  nxt.br_flag = !opr1[31];
            default: begin
                nxt.br_flag = 1'b0;
                nxt.br_addr = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        dec_o <= nxt;
    end

endmodule

//--- verilog.f
+incdir+source
source/decode_pkg.sv
source/inst_capture_stage.sv
source/control_decode_stage.sv
source/gpr_file.sv
source/operand_branch_stage.sv
source/decode_pipe.sv
sim/decode_pipe_properties.sv
sim/decode_pipe_tb.sv
